/* Makefile */
# Verilator build and run for the matrix-operand buffer

VERILATOR ?= verilator
TOP       ?= tb_mm_buff
FILELIST  ?= all.f
MDIR      ?= obj_dir
JOBS      ?= 4
VFLAGS    ?= --binary --timing --assert -j $(JOBS)
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(MDIR) -f $(FILELIST)

# The run passes only if the pass line shows up in the output
run: build
	@out="$$(./$(MDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST OK"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(MDIR)

/* all.f */
common/mm_buff_pkg.sv
hdl/mm_scratch_ram.sv
mm_buff/mm_buff_feed.sv
mm_buff/mm_buff_lane.sv
mm_buff/mm_buff_drain.sv
hdl/mm_buff_top.sv
tests/mm_buff_assert.sv
tests/tb_mm_buff.sv

/* common/mm_buff_pkg.sv */
package mm_buff_pkg;

    // Scratchpad line geometry
    localparam int LINE_BYTES = 16;
    localparam int LINE_W = LINE_BYTES * 8;

    // Byte address and its line part
    localparam int ADDR_W = 12;
    localparam int LINE_ADDR_W = 8;

    // Row and column counts are stored minus one
    localparam int CNT_W = 4;

    typedef struct packed {
        logic [ADDR_W-1:0] start_addr;
        logic [CNT_W-1:0]  row_len;
        logic [CNT_W-1:0]  col_len;
    } mm_cmd_t;

    // One aligned line handed to a lane
    typedef struct packed {
        logic              load;
        logic [LINE_W-1:0] data;
    } mm_lane_load_t;

endpackage

/* hdl/mm_buff_top.sv */
`timescale 1ns/1ps

module mm_buff_top #(
    parameter int NUM_LANES = 16,
    parameter int RAM_LINES = 256
) (
    input  logic                                clk,
    input  logic                                arst_n,

    input  logic                                ram_wr_en,
    input  logic [mm_buff_pkg::LINE_ADDR_W-1:0] ram_wr_line,
    input  logic [mm_buff_pkg::LINE_W-1:0]      ram_wr_data,

    input  logic                                cmd_vld,
    input  mm_buff_pkg::mm_cmd_t                cmd,

    output logic                                busy,
    output logic [NUM_LANES-1:0]                mxu_vld,
    output logic [mm_buff_pkg::LINE_W-1:0]      mxu_data,
    output logic                                mxu_end
);

    logic                                rd_en;
    logic [mm_buff_pkg::LINE_ADDR_W-1:0] rd_line;
    logic [mm_buff_pkg::LINE_W-1:0]      rd_data;

    mm_buff_pkg::mm_lane_load_t          lane_load [NUM_LANES];
    logic [mm_buff_pkg::CNT_W-1:0]       col_len;
    logic                                load_pend;

    logic [NUM_LANES-1:0]                lane_vld;
    logic [7:0]                          lane_byte [NUM_LANES];
    logic [NUM_LANES-1:0]                lane_last;

    mm_scratch_ram #(
        .RAM_LINES (RAM_LINES)
    ) u_ram (
        .clk     (clk),
        .wr_en   (ram_wr_en),
        .wr_line (ram_wr_line),
        .wr_data (ram_wr_data),
        .rd_en   (rd_en),
        .rd_line (rd_line),
        .rd_data (rd_data)
    );

    mm_buff_feed #(
        .NUM_LANES (NUM_LANES)
    ) u_feed (
        .clk        (clk),
        .arst_n     (arst_n),
        .cmd_vld    (cmd_vld),
        .cmd        (cmd),
        .rd_en      (rd_en),
        .rd_line    (rd_line),
        .rd_data    (rd_data),
        .lane_load  (lane_load),
        .col_len    (col_len),
        .load_pend  (load_pend),
        .stream_end (mxu_end),
        .busy       (busy)
    );

    // One lane per matrix row
    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        mm_buff_lane u_lane (
            .clk      (clk),
            .arst_n   (arst_n),
            .load     (lane_load[i]),
            .col_len  (col_len),
            .out_vld  (lane_vld[i]),
            .out_byte (lane_byte[i]),
            .out_last (lane_last[i])
        );
    end

    mm_buff_drain #(
        .NUM_LANES (NUM_LANES)
    ) u_drain (
        .lane_vld  (lane_vld),
        .lane_byte (lane_byte),
        .lane_last (lane_last),
        .load_pend (load_pend),
        .mxu_vld   (mxu_vld),
        .mxu_data  (mxu_data),
        .mxu_end   (mxu_end)
    );

endmodule

/* hdl/mm_scratch_ram.sv */
`timescale 1ns/1ps

module mm_scratch_ram #(
    parameter int RAM_LINES = 256
) (
    input  logic                                clk,

    input  logic                                wr_en,
    input  logic [mm_buff_pkg::LINE_ADDR_W-1:0] wr_line,
    input  logic [mm_buff_pkg::LINE_W-1:0]      wr_data,

    input  logic                                rd_en,
    input  logic [mm_buff_pkg::LINE_ADDR_W-1:0] rd_line,
    output logic [mm_buff_pkg::LINE_W-1:0]      rd_data
);

    logic [mm_buff_pkg::LINE_W-1:0] mem [RAM_LINES];

    // Preload path
    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_line] <= wr_data;
        end
    end

    // Registered read returns old data on a same-line write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_line];
        end
    end

endmodule

/* mm_buff/mm_buff_drain.sv */
`timescale 1ns/1ps

module mm_buff_drain #(
    parameter int NUM_LANES = 16
) (
    input  logic [NUM_LANES-1:0]           lane_vld,
    input  logic [7:0]                     lane_byte [NUM_LANES],
    input  logic [NUM_LANES-1:0]           lane_last,
    input  logic                           load_pend,

    output logic [NUM_LANES-1:0]           mxu_vld,
    output logic [mm_buff_pkg::LINE_W-1:0] mxu_data,
    output logic                           mxu_end
);

    logic any_last;
    logic any_short;

    assign mxu_vld = lane_vld;

    // Idle lanes put zero on the bus
    always_comb begin
        mxu_data = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            mxu_data[i*8 +: 8] = lane_vld[i] ? lane_byte[i] : 8'h00;
        end
    end

    assign any_last  = |lane_last;
    assign any_short = |(lane_vld & ~lane_last);

    // Lanes finish in order, so the last byte with nothing behind it ends the stream.
    // A lane still being loaded counts as behind it when rows are one column wide.
    assign mxu_end = any_last & ~any_short & ~load_pend;

endmodule

/* mm_buff/mm_buff_feed.sv */
`timescale 1ns/1ps

module mm_buff_feed #(
    parameter int NUM_LANES = 16
) (
    input  logic                                clk,
    input  logic                                arst_n,

    input  logic                                cmd_vld,
    input  mm_buff_pkg::mm_cmd_t                cmd,

    output logic                                rd_en,
    output logic [mm_buff_pkg::LINE_ADDR_W-1:0] rd_line,
    input  logic [mm_buff_pkg::LINE_W-1:0]      rd_data,

    output mm_buff_pkg::mm_lane_load_t          lane_load [NUM_LANES],
    output logic [mm_buff_pkg::CNT_W-1:0]       col_len,
    output logic                                load_pend,

    input  logic                                stream_end,
    output logic                                busy
);

    localparam int CNT_W = mm_buff_pkg::CNT_W;
    localparam int LINE_BYTES = mm_buff_pkg::LINE_BYTES;
    localparam int OFFS_W = $clog2(LINE_BYTES);

    logic                                rd_run_q;
    logic [CNT_W-1:0]                    rd_cnt_q;
    logic [mm_buff_pkg::LINE_ADDR_W-1:0] line_q;
    logic [CNT_W-1:0]                    rd_idx;
    logic [CNT_W-1:0]                    row_lim;
    logic                                rd_last;

    logic [CNT_W-1:0]                    row_len_q;
    logic [OFFS_W-1:0]                   offset_q;

    logic                                rd_vld_q;
    logic [CNT_W-1:0]                    lane_idx_q;
    logic [mm_buff_pkg::LINE_W-1:0]      aligned;

    // First read goes out straight from the command
    assign rd_en   = cmd_vld | rd_run_q;
    assign rd_line = cmd_vld ? cmd.start_addr[mm_buff_pkg::ADDR_W-1:OFFS_W] : line_q;
    assign rd_idx  = cmd_vld ? '0 : rd_cnt_q;
    assign row_lim = cmd_vld ? cmd.row_len : row_len_q;
    assign rd_last = (rd_idx == row_lim);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rd_run_q   <= 1'b0;
            rd_cnt_q   <= '0;
            rd_vld_q   <= 1'b0;
            lane_idx_q <= '0;
        end else begin
            rd_run_q <= rd_en & ~rd_last;
            rd_vld_q <= rd_en;
            if (rd_en) begin
                rd_cnt_q   <= rd_idx + 1'b1;
                lane_idx_q <= rd_idx;
            end
        end
    end

    // Line address wraps with the address width
    always_ff @(posedge clk) begin
        if (rd_en) begin
            line_q <= rd_line + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_vld) begin
            row_len_q <= cmd.row_len;
            col_len   <= cmd.col_len;
            offset_q  <= cmd.start_addr[OFFS_W-1:0];
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy <= 1'b0;
        end else if (cmd_vld) begin
            busy <= 1'b1;
        end else if (stream_end) begin
            busy <= 1'b0;
        end
    end

    // Rotate toward byte 0 by the start offset
    always_comb begin
        for (int b = 0; b < LINE_BYTES; b++) begin
            aligned[b*8 +: 8] = rd_data[((b + offset_q) % LINE_BYTES)*8 +: 8];
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_load
        assign lane_load[i].load = rd_vld_q & (lane_idx_q == CNT_W'(i));
        assign lane_load[i].data = aligned;
    end

    // A returning line still has to reach its lane
    assign load_pend = rd_vld_q;

endmodule

/* mm_buff/mm_buff_lane.sv */
`timescale 1ns/1ps

module mm_buff_lane (
    input  logic                          clk,
    input  logic                          arst_n,

    input  mm_buff_pkg::mm_lane_load_t    load,
    input  logic [mm_buff_pkg::CNT_W-1:0] col_len,

    output logic                          out_vld,
    output logic [7:0]                    out_byte,
    output logic                          out_last
);

    localparam int LINE_W = mm_buff_pkg::LINE_W;

    logic [LINE_W-1:0]             line_q;
    logic [mm_buff_pkg::CNT_W-1:0] col_cnt_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_vld   <= 1'b0;
            col_cnt_q <= '0;
        end else if (load.load) begin
            out_vld   <= 1'b1;
            col_cnt_q <= '0;
        end else if (out_vld) begin
            col_cnt_q <= col_cnt_q + 1'b1;
            // Row done after its last column
            if (out_last) begin
                out_vld <= 1'b0;
            end
        end
    end

    // Shift the row down one byte per column
    always_ff @(posedge clk) begin
        if (load.load) begin
            line_q <= load.data;
        end else if (out_vld) begin
            line_q <= {line_q[7:0], line_q[LINE_W-1:8]};
        end
    end

    assign out_byte = line_q[7:0];
    assign out_last = out_vld & (col_cnt_q == col_len);

endmodule

/* tests/mm_buff_assert.sv */
`timescale 1ns/1ps

module mm_buff_assert #(
    parameter int NUM_LANES = 16
) (
    input logic                 clk,
    input logic                 arst_n,
    input logic                 cmd_vld,
    input logic                 busy,
    input logic [NUM_LANES-1:0] mxu_vld,
    input logic                 mxu_end
);

    // New command only while idle
    cmd_when_idle: assert property (
        @(posedge clk) disable iff (!arst_n) cmd_vld |-> !busy
    ) else $error("command strobe while busy");

    end_single_cycle: assert property (
        @(posedge clk) disable iff (!arst_n) mxu_end |=> !mxu_end
    ) else $error("mxu_end wider than one cycle");

    end_inside_busy: assert property (
        @(posedge clk) disable iff (!arst_n) mxu_end |-> busy
    ) else $error("mxu_end outside a busy window");

    // Bus is quiet between streams
    idle_bus_quiet: assert property (
        @(posedge clk) disable iff (!arst_n) !busy |-> (mxu_vld == '0)
    ) else $error("lane valid while not busy");

endmodule

bind mm_buff_top mm_buff_assert #(
    .NUM_LANES (NUM_LANES)
) u_assert (
    .clk     (clk),
    .arst_n  (arst_n),
    .cmd_vld (cmd_vld),
    .busy    (busy),
    .mxu_vld (mxu_vld),
    .mxu_end (mxu_end)
);

/* tests/tb_mm_buff.sv */
`timescale 1ns/1ps

module tb_mm_buff;

    localparam int NUM_LANES = 16;
    localparam int RAM_LINES = 256;
    localparam int LINE_BYTES = mm_buff_pkg::LINE_BYTES;
    localparam int LINE_W = mm_buff_pkg::LINE_W;
    localparam int ADDR_W = mm_buff_pkg::ADDR_W;
    localparam int LINE_ADDR_W = mm_buff_pkg::LINE_ADDR_W;
    localparam int CNT_W = mm_buff_pkg::CNT_W;
    localparam int RESET_CYCLES = 3;

    // Expected DUT outputs in one cycle
    typedef struct packed {
        logic                 busy;
        logic                 fin;
        logic [NUM_LANES-1:0] vld;
        logic [LINE_W-1:0]    data;
    } expect_t;

    logic                   clk;
    logic                   arst_n;
    logic                   ram_wr_en;
    logic [LINE_ADDR_W-1:0] ram_wr_line;
    logic [LINE_W-1:0]      ram_wr_data;
    logic                   cmd_vld;
    mm_buff_pkg::mm_cmd_t   cmd;
    logic                   busy;
    logic [NUM_LANES-1:0]   mxu_vld;
    logic [LINE_W-1:0]      mxu_data;
    logic                   mxu_end;

    logic [LINE_W-1:0]      shadow [RAM_LINES];
    mm_buff_pkg::mm_cmd_t   cmd_q [$];
    int                     gap_q [$];
    logic [15:0]            lfsr_q = 16'd51519;
    int                     run_limit = 0;
    int                     run_cycles = 0;
    int                     cycle_no = 0;
    int                     cmd_cycle = 0;
    logic                   have_cmd = 1'b0;
    mm_buff_pkg::mm_cmd_t   cur_cmd;

    mm_buff_top #(
        .NUM_LANES (NUM_LANES),
        .RAM_LINES (RAM_LINES)
    ) dut (
        .clk         (clk),
        .arst_n      (arst_n),
        .ram_wr_en   (ram_wr_en),
        .ram_wr_line (ram_wr_line),
        .ram_wr_data (ram_wr_data),
        .cmd_vld     (cmd_vld),
        .cmd         (cmd),
        .busy        (busy),
        .mxu_vld     (mxu_vld),
        .mxu_data    (mxu_data),
        .mxu_end     (mxu_end)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            v = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic report_mismatch(input string name, input logic [LINE_W-1:0] got,
                                   input logic [LINE_W-1:0] exp);
        abort_run($sformatf("MISMATCH at time %0t: %s got %h expected %h",
                            $time, name, got, exp));
    endtask

    function automatic mm_buff_pkg::mm_cmd_t make_cmd(input int line, input int offs,
                                                      input int rows, input int cols);
        mm_buff_pkg::mm_cmd_t c;
        c.start_addr = ADDR_W'(line * LINE_BYTES + offs);
        c.row_len    = CNT_W'(rows);
        c.col_len    = CNT_W'(cols);
        return c;
    endfunction

    // Command cycle, the stream itself and any idle gap
    task automatic add_cmd(input mm_buff_pkg::mm_cmd_t c, input int gap);
        cmd_q.push_back(c);
        gap_q.push_back(gap);
        run_limit += int'(c.row_len) + int'(c.col_len) + 2 + 1 + gap;
    endtask

    // Lane k carries row k from cycle k+2 on, rotated by the start offset
    function automatic expect_t expected_outputs(input mm_buff_pkg::mm_cmd_t c, input int d);
        expect_t                e;
        int                     rows;
        int                     cols;
        int                     offs;
        int                     first_line;
        int                     j;
        int                     bsel;
        logic [LINE_ADDR_W-1:0] ln;
        logic [7:0]             b;
        e = '0;
        rows = int'(c.row_len);
        cols = int'(c.col_len);
        offs = int'(c.start_addr) % LINE_BYTES;
        first_line = int'(c.start_addr) / LINE_BYTES;
        for (int k = 0; k < NUM_LANES; k++) begin
            j = d - k - 2;
            if (k <= rows && j >= 0 && j <= cols) begin
                ln = LINE_ADDR_W'((first_line + k) % RAM_LINES);
                bsel = (offs + j) % LINE_BYTES;
                b = 8'(shadow[ln] >> (8 * bsel));
                e.vld = e.vld | (NUM_LANES'(1) << k);
                e.data = e.data | (LINE_W'(b) << (8 * k));
            end
        end
        e.fin = (d == rows + cols + 2);
        e.busy = (d >= 1) && (d <= rows + cols + 2);
        return e;
    endfunction

    task automatic build_tests();
        logic [LINE_ADDR_W-1:0] ln;
        logic [LINE_W-1:0]      line_data;
        for (int i = 0; i < RAM_LINES; i++) begin
            ln = LINE_ADDR_W'(i);
            line_data = '0;
            for (int w = 0; w < LINE_W / 32; w++) begin
                line_data = {line_data[LINE_W-33:0], rand_bits(32)};
            end
            shadow[ln] = line_data;
        end
        add_cmd(make_cmd(5, 0, 15, 15), 0);
        repeat (4) begin
            add_cmd(make_cmd(int'(rand_bits(8)), 1 + int'(rand_bits(4)) % 15, 15, 15), 0);
        end
        add_cmd(make_cmd(int'(rand_bits(8)), 0, 0, 0), 0);
        add_cmd(make_cmd(int'(rand_bits(8)), 9, 0, 15), 0);
        add_cmd(make_cmd(int'(rand_bits(8)), 3, 15, 0), 0);
        add_cmd(make_cmd(int'(rand_bits(8)), 0, 1, 0), 2);
        // Wrap past the last RAM line
        add_cmd(make_cmd(RAM_LINES - 3, 7, 15, 9), 0);
        add_cmd(make_cmd(RAM_LINES - 1, 15, 4, 15), 0);
        repeat (12) begin
            add_cmd(make_cmd(int'(rand_bits(8)), int'(rand_bits(4)), int'(rand_bits(4)),
                             int'(rand_bits(4))), int'(rand_bits(2)));
        end
        run_limit += RAM_LINES + RESET_CYCLES + 100;
    endtask

    initial begin
        arst_n      = 1'b0;
        ram_wr_en   = 1'b0;
        ram_wr_line = '0;
        ram_wr_data = '0;
        cmd_vld     = 1'b0;
        cmd         = '0;
        build_tests();
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n = 1'b1;
        for (int i = 0; i < RAM_LINES; i++) begin
            ram_wr_en   = 1'b1;
            ram_wr_line = LINE_ADDR_W'(i);
            ram_wr_data = shadow[LINE_ADDR_W'(i)];
            @(negedge clk);
        end
        ram_wr_en = 1'b0;
        // Each command goes out as soon as the previous stream is done
        for (int i = 0; i < cmd_q.size(); i++) begin
            while (busy) @(negedge clk);
            repeat (gap_q[i]) @(negedge clk);
            cmd_vld = 1'b1;
            cmd     = cmd_q[i];
            @(negedge clk);
            cmd_vld = 1'b0;
        end
        while (busy) @(negedge clk);
        repeat (4) @(negedge clk);
        $display("TEST OK");
        $finish;
    end

    always @(posedge clk) begin
        expect_t e;
        if (have_cmd) begin
            e = expected_outputs(cur_cmd, cycle_no - cmd_cycle);
        end else begin
            e = '0;
        end
        if (arst_n === 1'b1) begin
            assert (busy === e.busy)
                else report_mismatch("busy", LINE_W'(busy), LINE_W'(e.busy));
            assert (mxu_vld === e.vld)
                else report_mismatch("mxu_vld", LINE_W'(mxu_vld), LINE_W'(e.vld));
            assert (mxu_data === e.data)
                else report_mismatch("mxu_data", mxu_data, e.data);
            assert (mxu_end === e.fin)
                else report_mismatch("mxu_end", LINE_W'(mxu_end), LINE_W'(e.fin));
        end
        if (cmd_vld === 1'b1) begin
            have_cmd  = 1'b1;
            cur_cmd   = cmd;
            cmd_cycle = cycle_no;
        end
        cycle_no++;
    end

    always @(posedge clk) begin
        run_cycles++;
        if (run_limit > 0 && run_cycles >= run_limit) begin
            abort_run($sformatf("timeout after %0d cycles", run_cycles));
        end
    end

endmodule
